// File: logic/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int word_width     = 16;
    localparam int reg_count      = 8;
    localparam int reg_addr_width = 3;

    // ------------------------------------------------------------
    // Opcodes and operation codes
    // ------------------------------------------------------------
    localparam logic [2:0] opc_alu  = 3'b101;
    localparam logic [2:0] opc_move = 3'b110;

    localparam logic [1:0] alu_add = 2'b00;
    localparam logic [1:0] alu_cmp = 2'b01;
    localparam logic [1:0] alu_and = 2'b10;
    localparam logic [1:0] alu_mvn = 2'b11;

    localparam logic [1:0] mov_reg = 2'b00;  // Move from Rm through the shifter.
    localparam logic [1:0] mov_imm = 2'b10;  // Move of the sign-extended imm8.

    localparam logic [1:0] sh_none = 2'b00;
    localparam logic [1:0] sh_lsl  = 2'b01;
    localparam logic [1:0] sh_lsr  = 2'b10;
    localparam logic [1:0] sh_asr  = 2'b11;

    localparam logic [1:0] rsel_rd = 2'b01;
    localparam logic [1:0] rsel_rn = 2'b10;

    localparam logic [1:0] wb_c   = 2'b00;
    localparam logic [1:0] wb_imm = 2'b10;

    // ------------------------------------------------------------
    // Instruction formats
    // ------------------------------------------------------------
    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] op;
        logic [2:0] rn;
        logic [2:0] rd;
        logic [1:0] shift;
        logic [2:0] rm;
    } instr_alu_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] op;
        logic [2:0] rn;
        logic [7:0] imm8;
    } instr_imm_t;

    typedef union packed {
        instr_alu_t alu;
        instr_imm_t imm;
    } instr_u;

    typedef struct packed {
        logic [2:0]                opcode;
        logic [1:0]                op;
        logic [reg_addr_width-1:0] rn;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rm;
        logic [1:0]                shift;
        logic [word_width-1:0]     sximm8;
        logic                      illegal;
    } decode_t;

    typedef struct packed {
        logic       en_a;
        logic       en_b;
        logic       en_c;
        logic       en_status;
        logic       w_en;
        logic [1:0] reg_sel;
        logic [1:0] wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } status_t;

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::instr_u instr,
    input  logic            load,
    output cpu_pkg::decode_t dec
);
    import cpu_pkg::*;

    instr_u ir;
    logic   is_imm;
    logic   is_alu;
    logic   is_move;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (load) begin
            ir <= instr;  // Captured on the handshake edge.
        end
    end

    // Opcode, op and rn sit at the same bits in both views.
    assign is_alu  = (ir.alu.opcode == opc_alu);
    assign is_move = (ir.alu.opcode == opc_move);
    assign is_imm  = is_move && (ir.imm.op == mov_imm);

    always_comb begin
        dec.opcode = ir.alu.opcode;
        dec.op     = ir.alu.op;
        dec.rn     = ir.alu.rn;
        if (is_imm) begin
            dec.rd     = '0;
            dec.rm     = '0;
            dec.shift  = sh_none;
            dec.sximm8 = {{(word_width-8){ir.imm.imm8[7]}}, ir.imm.imm8};
        end else begin
            dec.rd     = ir.alu.rd;
            dec.rm     = ir.alu.rm;
            dec.shift  = ir.alu.shift;
            dec.sximm8 = '0;
        end
        dec.illegal = !(is_alu || is_imm || (is_move && ir.alu.op == mov_reg));
    end

endmodule

// File: logic/cpu_controller.sv
`timescale 1ns/1ps

module cpu_controller (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_valid,
    input  cpu_pkg::decode_t dec,
    output logic             waiting,
    output cpu_pkg::ctrl_t   ctrl
);
    import cpu_pkg::*;

    typedef enum logic [3:0] {
        s_wait,
        s_decode,
        s_alu,
        s_move,
        s_write_imm,
        s_load_a,
        s_load_b,
        s_compute,
        s_write_rd,
        s_status
    } state_t;

    state_t state;
    state_t state_next;
    logic   is_cmp;

    assign is_cmp = (dec.opcode == opc_alu) && (dec.op == alu_cmp);

    // ------------------------------------------------------------
    // State register and next-state logic
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_wait;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_wait: begin
                if (instr_valid) begin
                    state_next = s_decode;
                end
            end
            s_decode: begin
                if (dec.illegal) begin
                    state_next = s_wait;  // Dropped without a write.
                end else if (dec.opcode == opc_alu) begin
                    state_next = s_alu;
                end else begin
                    state_next = s_move;
                end
            end
            s_alu: begin
                if (dec.op == alu_mvn) begin
                    state_next = s_load_b;  // MVN has no Rn operand.
                end else begin
                    state_next = s_load_a;
                end
            end
            s_move: begin
                if (dec.op == mov_imm) begin
                    state_next = s_write_imm;
                end else begin
                    state_next = s_load_b;
                end
            end
            s_load_a:    state_next = s_load_b;
            s_load_b:    state_next = s_compute;
            s_compute: begin
                if (is_cmp) begin
                    state_next = s_status;
                end else begin
                    state_next = s_write_rd;
                end
            end
            s_write_imm: state_next = s_wait;
            s_write_rd:  state_next = s_wait;
            s_status:    state_next = s_wait;
            default:     state_next = s_wait;
        endcase
    end

    // ------------------------------------------------------------
    // Moore outputs
    // ------------------------------------------------------------
    always_comb begin
        waiting = 1'b0;
        ctrl    = '0;
        case (state)
            s_wait: begin
                waiting = 1'b1;
            end
            s_load_a: begin
                ctrl.en_a    = 1'b1;
                ctrl.reg_sel = rsel_rn;
            end
            s_load_b: begin
                ctrl.en_b = 1'b1;  // The datapath reads Rm here.
            end
            s_compute: begin
                ctrl.en_c = 1'b1;
            end
            s_status: begin
                ctrl.en_status = 1'b1;
            end
            s_write_rd: begin
                ctrl.w_en    = 1'b1;
                ctrl.reg_sel = rsel_rd;
                ctrl.wb_sel  = wb_c;
            end
            s_write_imm: begin
                ctrl.w_en    = 1'b1;
                ctrl.reg_sel = rsel_rn;
                ctrl.wb_sel  = wb_imm;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               w_en,
    input  logic [cpu_pkg::reg_addr_width-1:0] w_addr,
    input  logic [cpu_pkg::reg_addr_width-1:0] r_addr,
    input  logic [cpu_pkg::word_width-1:0]     w_data,
    output logic [cpu_pkg::word_width-1:0]     r_data
);
    import cpu_pkg::*;

    logic [word_width-1:0] regs [reg_count];

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en) begin
            regs[w_addr] <= w_data;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    assign r_data = regs[r_addr];  // A and B see the read in the same cycle.

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                               clk,
    input  logic                               rst_n,
    input  cpu_pkg::decode_t                   dec,
    input  cpu_pkg::ctrl_t                     ctrl,
    output logic [cpu_pkg::reg_addr_width-1:0] wb_reg,
    output logic [cpu_pkg::word_width-1:0]     wb_data,
    output cpu_pkg::status_t                   status
);
    import cpu_pkg::*;

    localparam int msb = word_width - 1;

    logic [reg_addr_width-1:0] sel_addr;
    logic [word_width-1:0]     r_data;
    logic [word_width-1:0]     a_q;
    logic [word_width-1:0]     b_q;
    logic [word_width-1:0]     c_q;
    logic [word_width-1:0]     b_sh;
    logic [word_width-1:0]     ain;
    logic [word_width-1:0]     alu_out;
    status_t                   status_next;

    // ------------------------------------------------------------
    // Register file and address select
    // ------------------------------------------------------------
    always_comb begin
        if (ctrl.en_b) begin
            sel_addr = dec.rm;
        end else if (ctrl.reg_sel == rsel_rd) begin
            sel_addr = dec.rd;
        end else begin
            sel_addr = dec.rn;
        end
    end

    register_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .w_en   (ctrl.w_en),
        .w_addr (sel_addr),
        .r_addr (sel_addr),
        .w_data (wb_data),
        .r_data (r_data)
    );

    // ------------------------------------------------------------
    // Operand and result registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctrl.en_a) begin
            a_q <= r_data;
        end
        if (ctrl.en_b) begin
            b_q <= r_data;
        end
        if (ctrl.en_c) begin
            c_q <= alu_out;
        end
    end

    // ------------------------------------------------------------
    // Shifter and ALU
    // ------------------------------------------------------------
    always_comb begin
        case (dec.shift)
            sh_lsl:  b_sh = {b_q[msb-1:0], 1'b0};
            sh_lsr:  b_sh = {1'b0, b_q[msb:1]};
            sh_asr:  b_sh = {b_q[msb], b_q[msb:1]};
            default: b_sh = b_q;
        endcase
    end

    // A move-register has op 00 and adds the shifted Rm to zero.
    assign ain = (dec.opcode == opc_move) ? '0 : a_q;

    always_comb begin
        case (dec.op)
            alu_add: alu_out = ain + b_sh;
            alu_cmp: alu_out = ain - b_sh;
            alu_and: alu_out = ain & b_sh;
            default: alu_out = ~b_sh;
        endcase
    end

    // ------------------------------------------------------------
    // Status register
    // ------------------------------------------------------------
    // C holds Rn - shifted Rm while A and B are still the operands.
    assign status_next.z = (c_q == '0);
    assign status_next.n = c_q[msb];
    assign status_next.v = (a_q[msb] != b_sh[msb]) && (c_q[msb] != a_q[msb]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
        end else if (ctrl.en_status) begin
            status <= status_next;
        end
    end

    assign wb_reg  = sel_addr;
    assign wb_data = (ctrl.wb_sel == wb_imm) ? dec.sximm8 : c_q;

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::instr_u  instr,
    input  logic             instr_valid,
    output logic             instr_ready,
    output logic             wb_valid,
    output logic [2:0]       wb_reg,
    output logic [15:0]      wb_data,
    output cpu_pkg::status_t status
);
    import cpu_pkg::*;

    decode_t dec;
    ctrl_t   ctrl;
    logic    waiting;
    logic    load;

    assign load        = instr_valid && waiting;  // The handshake transfer.
    assign instr_ready = waiting;
    assign wb_valid    = ctrl.w_en;

    instr_decoder u_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .instr (instr),
        .load  (load),
        .dec   (dec)
    );

    cpu_controller u_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .dec         (dec),
        .waiting     (waiting),
        .ctrl        (ctrl)
    );

    datapath u_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .ctrl    (ctrl),
        .wb_reg  (wb_reg),
        .wb_data (wb_data),
        .status  (status)
    );

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;  // Half of the 8 ns period.
        end
    end

endmodule

// File: tests/cpu_controller_sva.sv
`timescale 1ns/1ps

module cpu_controller_sva (
    input logic             clk,
    input logic             rst_n,
    input logic             waiting,
    input cpu_pkg::decode_t dec,
    input cpu_pkg::ctrl_t   ctrl
);
    import cpu_pkg::*;

    int fail_count = 0;

    onehot_enables: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.en_a, ctrl.en_b, ctrl.en_c}))
        else begin
            fail_count++;
            $error("more than one of en_a, en_b and en_c is high");
        end

    no_write_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        !(waiting && ctrl.w_en))
        else begin
            fail_count++;
            $error("w_en is high while the controller waits");
        end

    status_only_cmp: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.en_status |-> (dec.opcode == opc_alu && dec.op == alu_cmp))
        else begin
            fail_count++;
            $error("en_status is high for an instruction other than CMP");
        end

    // The controller comes out of reset in its wait state.
    reset_to_wait: assert property (@(posedge clk) !rst_n |=> waiting)
        else begin
            fail_count++;
            $error("waiting is low in the cycle after reset");
        end

endmodule

bind cpu_controller cpu_controller_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .waiting (waiting),
    .dec     (dec),
    .ctrl    (ctrl)
);

// File: tests/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int timeout_cycles = 40;

    typedef struct packed {
        logic [15:0] word;
        logic        write;
        logic [2:0]  rd;
        logic [15:0] data;
        logic [2:0]  flags;  // Expected z, n, v once the instruction is done.
    } vector_t;

    logic        clk;
    logic        rst_n;
    instr_u      instr;
    logic        instr_valid;
    logic        instr_ready;
    logic        wb_valid;
    logic [2:0]  wb_reg;
    logic [15:0] wb_data;
    status_t     status;

    vector_t     vectors[$];
    logic [31:0] rng_state;
    int          errors;
    int          timeouts;
    int          checks;

    clock_gen u_clock (
        .clk (clk)
    );

    cpu_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .status      (status)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------------------------------------
    // Vector file
    // ------------------------------------------------------------
    task automatic read_vectors();
        int          fd;
        int          count;
        string       line;
        logic [31:0] f_word;
        logic [31:0] f_write;
        logic [31:0] f_rd;
        logic [31:0] f_data;
        logic [31:0] f_flags;
        vector_t     v;
        fd = $fopen("tests/cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/cpu_vectors.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Comment lines match no hex field and give a count of zero.
                count = $sscanf(line, "%h %h %h %h %h", f_word, f_write, f_rd, f_data, f_flags);
                if (count == 5) begin
                    v.word  = f_word[15:0];
                    v.write = f_write[0];
                    v.rd    = f_rd[2:0];
                    v.data  = f_data[15:0];
                    v.flags = f_flags[2:0];
                    vectors.push_back(v);
                end else if (count > 0) begin
                    $display("malformed vector line: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------
    // Handshake and result checks
    // ------------------------------------------------------------
    task automatic wait_ready(output bit ok);
        int cycles;
        cycles = 0;
        while (instr_ready !== 1'b1 && cycles < timeout_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (instr_ready === 1'b1);
        if (!ok) begin
            $display("timeout: instr_ready stayed low for %0d cycles", timeout_cycles);
            timeouts++;
        end
    endtask

    task automatic run_instruction(input vector_t v, input int idx, output bit ok);
        int cycles;
        bit seen_write;
        cycles     = 0;
        seen_write = 1'b0;
        while (instr_ready !== 1'b1 && cycles < timeout_cycles) begin
            if (wb_valid === 1'b1) begin
                if (!v.write || seen_write) begin
                    $display("vector %0d made an unexpected write to r%0d", idx, wb_reg);
                    errors++;
                end else begin
                    checks++;
                    if (wb_reg !== v.rd) begin
                        $display("error: wb_reg got %h expected %h (vector %0d)",
                                 wb_reg, v.rd, idx);
                        errors++;
                    end
                    if (wb_data !== v.data) begin
                        $display("error: wb_data got %h expected %h (vector %0d)",
                                 wb_data, v.data, idx);
                        errors++;
                    end
                end
                seen_write = 1'b1;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (instr_ready === 1'b1);
        if (!ok) begin
            $display("timeout: vector %0d did not complete in %0d cycles", idx, timeout_cycles);
            timeouts++;
        end else begin
            if (v.write && !seen_write) begin
                $display("instr_ready returned before the write-back of vector %0d", idx);
                errors++;
            end
            checks++;
            if ({status.z, status.n, status.v} !== v.flags) begin
                $display("error: status got %h expected %h (vector %0d)",
                         {status.z, status.n, status.v}, v.flags, idx);
                errors++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int idx;
        int gap;
        int g;
        bit ok;
        bit held;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        errors      = 0;
        timeouts    = 0;
        checks      = 0;
        rng_state   = 32'hbbe8b3d4;
        read_vectors();
        if (vectors.size() == 0) begin
            $display("no vectors were read");
            errors++;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (instr_ready !== 1'b1) begin
            $display("error: instr_ready got %h expected %h after reset", instr_ready, 1'b1);
            errors++;
        end
        if (wb_valid !== 1'b0) begin
            $display("error: wb_valid got %h expected %h after reset", wb_valid, 1'b0);
            errors++;
        end
        if ({status.z, status.n, status.v} !== 3'b000) begin
            $display("error: status got %h expected %h after reset",
                     {status.z, status.n, status.v}, 3'b000);
            errors++;
        end
        ok   = 1'b1;
        held = 1'b0;
        for (idx = 0; idx < vectors.size() && ok; idx++) begin
            if (!held) begin
                instr       = vectors[idx].word;
                instr_valid = 1'b1;
            end
            wait_ready(ok);
            if (ok) begin
                @(posedge clk);  // Transfer edge.
                #1;
                if (instr_ready !== 1'b0) begin
                    $display("error: instr_ready got %h expected %h after transfer (vector %0d)",
                             instr_ready, 1'b0, idx);
                    errors++;
                end
                rng_state = xorshift32(rng_state);
                held = rng_state[0] && (idx + 1 < vectors.size());
                if (held) begin
                    instr = vectors[idx + 1].word;  // Kept valid through the busy cycles.
                end else begin
                    instr_valid = 1'b0;
                    instr       = rng_state[31:16];  // Must be ignored while valid is low.
                end
                run_instruction(vectors[idx], idx, ok);
                gap = held ? 0 : {30'b0, rng_state[2:1]};
                for (g = 0; g < gap; g++) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        instr_valid = 1'b0;
        errors = errors + uut.u_controller.u_sva.fail_count;
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: files.f
logic/cpu_pkg.sv
logic/instr_decoder.sv
logic/cpu_controller.sv
logic/register_file.sv
logic/datapath.sv
logic/cpu_top.sv
tests/clock_gen.sv
tests/cpu_controller_sva.sv
tests/tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cpu -f files.f -o tb_cpu
./obj_dir/tb_cpu | tee sim.log

# The simulation exits cleanly on a failed run too, so the log decides.
grep -q "test passed" sim.log

// File: tests/cpu_vectors.txt
# instr  write  reg  data  flags   (all hex, flags = {z, n, v} after the instruction)
# reg and data are ignored when write is 0.
D005 1 0 0005 0
D1FD 1 1 FFFD 0
D27F 1 2 007F 0
D380 1 3 FF80 0
C081 1 4 FFFD 0
C0A8 1 5 000A 0
C0D2 1 6 003F 0
C0FB 1 7 FFC0 0
A800 0 0 0000 4
A041 1 2 0002 4
B4A6 1 5 003D 4
B8C0 1 6 FFFA 4
1234 0 0 0000 4
C9FF 0 0 0000 4
A900 0 0 0000 2
A58F 1 4 FFBD 2
D0FF 1 0 FFFF 2
B830 1 1 8000 2
C050 1 2 7FFF 2
A902 0 0 0000 1
B061 1 3 8000 1
AA01 0 0 0000 3
A6C6 1 6 FFF4 3
